//--- cps_rom_pkg.sv
/*
 * CPS ROM router shared definitions
 * SDRAM bank request and response structs, client address widths
 * and the base of each ROM client inside its bank
 */
`default_nettype none

package cps_rom_pkg;

    // SDRAM addresses count 16-bit words
    localparam int sdram_aw = 22;
    localparam int line_w   = 32;

    typedef logic [sdram_aw-1:0] sdram_addr_t;

    // Data as returned on data_read, also the cache line of a slot
    typedef logic [line_w-1:0] line_t;

    // Client payloads narrower than a line
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // Read request to a read-only bank
    typedef struct packed {
        logic        rd;
        sdram_addr_t addr;
    } bank_req_t;

    // Bank answer, rdy qualifies data_read
    typedef struct packed {
        logic ack;
        logic rdy;
    } bank_rsp_t;

    // Client address widths
    localparam int main_aw = 21;   // 16-bit words
    localparam int snd_aw  = 19;   // bytes
    localparam int pcm_aw  = 23;   // bytes
    localparam int gfx_aw  = 20;   // 32-bit words

    // Bank 1 holds sound code then PCM samples
    localparam sdram_addr_t snd_offset  = 22'h00_0000;
    localparam sdram_addr_t pcm_offset  = 22'h08_0000;

    // Bank 2 holds only the main CPU ROM
    localparam sdram_addr_t main_offset = 22'h00_0000;

    // Bank 3 holds both graphics ports
    localparam sdram_addr_t rom0_offset = 22'h00_0000;
    localparam sdram_addr_t rom1_offset = 22'h10_0000;

endpackage

`default_nettype wire

//--- rom_slot.sv
/*
 * ROM client slot
 * Keeps one 32-bit line of SDRAM data with its tag, answers hits in the
 * same cycle and requests a line fill from the bank arbiter on a miss.
 * The client word is picked out of the line by its low address bits.
 */
`timescale 1ns/100ps
`default_nettype none

module rom_slot #(
    parameter type data_t = logic [7:0],
    parameter int addr_w = 19,
    parameter cps_rom_pkg::sdram_addr_t offset = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Client side
    input  logic                     cs,
    input  logic [addr_w-1:0]        addr,
    output data_t                    data,
    output logic                     ok,
    // Arbiter side
    output logic                     req,
    output cps_rom_pkg::sdram_addr_t line_addr,
    input  logic                     fill,
    input  cps_rom_pkg::line_t       data_read
);

    // Client words per line and the address bits that pick one
    localparam int dw    = $bits(data_t);
    localparam int nsel  = cps_rom_pkg::line_w / dw;
    localparam int sel_w = $clog2(nsel);
    localparam int tag_w = addr_w - sel_w;

    localparam logic [addr_w-1:0] sel_mask = addr_w'(nsel - 1);

    cps_rom_pkg::line_t line_q;
    logic [tag_w-1:0]   tag_q;
    logic               valid_q;

    logic [tag_w-1:0]   tag_in;
    logic [addr_w-1:0]  sel_idx;
    logic               hit;

    assign tag_in  = addr[addr_w-1:sel_w];
    assign sel_idx = addr & sel_mask;

    assign hit = valid_q && (tag_q == tag_in);

    // Hits answer in the same cycle
    assign ok  = cs && hit;

    // Request stays up until the fill lands in the line
    assign req = cs && !hit;

    // Each line is two 16-bit words, so the word address is even
    assign line_addr = offset + cps_rom_pkg::sdram_addr_t'({tag_in, 1'b0});

    // Byte 0 of the line is the least significant one
    assign data = data_t'(line_q >> (sel_idx * dw));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (fill) begin
            valid_q <= 1'b1;
        end
    end

    // Line contents and tag
    always_ff @(posedge clk) begin
        if (fill) begin
            line_q <= data_read;
            tag_q  <= tag_in;
        end
    end

endmodule

`default_nettype wire

//--- bank_arbiter.sv
/*
 * Read arbiter for one SDRAM bank
 * Serves the requesting slots in round-robin order, one read at a time,
 * with the rd / ack / rdy handshake of the SDRAM controller.
 */
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter #(
    parameter int nslot = 2
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Slot side
    input  logic [nslot-1:0]                     req,
    input  cps_rom_pkg::sdram_addr_t [nslot-1:0] line_addr,
    output logic [nslot-1:0]                     fill,
    // SDRAM bank side
    output cps_rom_pkg::bank_req_t               bank_req,
    input  cps_rom_pkg::bank_rsp_t               bank_rsp
);

    localparam int idx_w = (nslot > 1) ? $clog2(nslot) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_rdy
    } state_t;

    state_t                   state_q;
    logic                     rd_q;
    cps_rom_pkg::sdram_addr_t addr_q;
    logic [idx_w-1:0]         grant_q;
    logic [idx_w-1:0]         last_q;

    logic [idx_w-1:0]         next_idx;
    logic                     found;

    // Next requester after the one served last
    always_comb begin : pick
        int cand;
        found    = 1'b0;
        next_idx = last_q;
        for (int k = 1; k <= nslot; k++) begin
            cand = (int'(last_q) + k) % nslot;
            if (!found && req[cand]) begin
                found    = 1'b1;
                next_idx = idx_w'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            rd_q    <= 1'b0;
            grant_q <= '0;
            last_q  <= idx_w'(nslot - 1);
        end else begin
            case (state_q)
                st_idle: begin
                    if (found) begin
                        rd_q    <= 1'b1;
                        grant_q <= next_idx;
                        state_q <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    // Address stays put until the controller takes it
                    if (bank_rsp.ack) begin
                        rd_q    <= 1'b0;
                        state_q <= st_wait_rdy;
                    end
                end
                st_wait_rdy: begin
                    if (bank_rsp.rdy) begin
                        last_q  <= grant_q;
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Read address latched at grant
    always_ff @(posedge clk) begin
        if (state_q == st_idle && found) begin
            addr_q <= line_addr[next_idx];
        end
    end

    // rdy belongs to the granted slot
    always_comb begin
        fill = '0;
        if (state_q == st_wait_rdy && bank_rsp.rdy) begin
            fill[grant_q] = 1'b1;
        end
    end

    assign bank_req = '{rd: rd_q, addr: addr_q};

endmodule

`default_nettype wire

//--- cps_rom_router.sv
/*
 * CPS ROM router
 * Puts the five read-only ROM clients onto SDRAM banks 1 to 3.
 * Bank 1 takes sound and PCM, bank 2 the main CPU, bank 3 graphics.
 */
`timescale 1ns/100ps
`default_nettype none

module cps_rom_router (
    input  logic                              clk,
    input  logic                              rst_n,
    // Main CPU ROM
    input  logic                              main_rom_cs,
    input  logic [cps_rom_pkg::main_aw-1:0]   main_rom_addr,
    output cps_rom_pkg::word_t                main_rom_data,
    output logic                              main_rom_ok,
    // Sound CPU ROM
    input  logic                              snd_cs,
    input  logic [cps_rom_pkg::snd_aw-1:0]    snd_addr,
    output cps_rom_pkg::byte_t                snd_data,
    output logic                              snd_ok,
    // Sample ROM
    input  logic                              pcm_cs,
    input  logic [cps_rom_pkg::pcm_aw-1:0]    pcm_addr,
    output cps_rom_pkg::byte_t                pcm_data,
    output logic                              pcm_ok,
    // Graphics ROM ports
    input  logic                              rom0_cs,
    input  logic [cps_rom_pkg::gfx_aw-1:0]    rom0_addr,
    output cps_rom_pkg::line_t                rom0_data,
    output logic                              rom0_ok,
    input  logic                              rom1_cs,
    input  logic [cps_rom_pkg::gfx_aw-1:0]    rom1_addr,
    output cps_rom_pkg::line_t                rom1_data,
    output logic                              rom1_ok,
    // SDRAM banks
    output cps_rom_pkg::bank_req_t            ba1_req,
    output cps_rom_pkg::bank_req_t            ba2_req,
    output cps_rom_pkg::bank_req_t            ba3_req,
    input  cps_rom_pkg::bank_rsp_t            ba1_rsp,
    input  cps_rom_pkg::bank_rsp_t            ba2_rsp,
    input  cps_rom_pkg::bank_rsp_t            ba3_rsp,
    input  cps_rom_pkg::line_t                data_read
);

    // Slot 0 is sound, slot 1 is PCM
    logic [1:0]                     ba1_slot_req;
    logic [1:0]                     ba1_fill;
    cps_rom_pkg::sdram_addr_t [1:0] ba1_line;

    logic                           ba2_slot_req;
    logic                           ba2_fill;
    cps_rom_pkg::sdram_addr_t       ba2_line;

    // Slot 0 is rom0, slot 1 is rom1
    logic [1:0]                     ba3_slot_req;
    logic [1:0]                     ba3_fill;
    cps_rom_pkg::sdram_addr_t [1:0] ba3_line;

    rom_slot #(
        .data_t   ( cps_rom_pkg::byte_t      ),
        .addr_w   ( cps_rom_pkg::snd_aw      ),
        .offset   ( cps_rom_pkg::snd_offset  )
    ) u_snd (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .cs       ( snd_cs          ),
        .addr     ( snd_addr        ),
        .data     ( snd_data        ),
        .ok       ( snd_ok          ),
        .req      ( ba1_slot_req[0] ),
        .line_addr( ba1_line[0]     ),
        .fill     ( ba1_fill[0]     ),
        .data_read( data_read       )
    );

    rom_slot #(
        .data_t   ( cps_rom_pkg::byte_t      ),
        .addr_w   ( cps_rom_pkg::pcm_aw      ),
        .offset   ( cps_rom_pkg::pcm_offset  )
    ) u_pcm (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .cs       ( pcm_cs          ),
        .addr     ( pcm_addr        ),
        .data     ( pcm_data        ),
        .ok       ( pcm_ok          ),
        .req      ( ba1_slot_req[1] ),
        .line_addr( ba1_line[1]     ),
        .fill     ( ba1_fill[1]     ),
        .data_read( data_read       )
    );

    bank_arbiter #(.nslot(2)) u_ba1 (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .req      ( ba1_slot_req ),
        .line_addr( ba1_line     ),
        .fill     ( ba1_fill     ),
        .bank_req ( ba1_req      ),
        .bank_rsp ( ba1_rsp      )
    );

    rom_slot #(
        .data_t   ( cps_rom_pkg::word_t      ),
        .addr_w   ( cps_rom_pkg::main_aw     ),
        .offset   ( cps_rom_pkg::main_offset )
    ) u_main (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .cs       ( main_rom_cs     ),
        .addr     ( main_rom_addr   ),
        .data     ( main_rom_data   ),
        .ok       ( main_rom_ok     ),
        .req      ( ba2_slot_req    ),
        .line_addr( ba2_line        ),
        .fill     ( ba2_fill        ),
        .data_read( data_read       )
    );

    bank_arbiter #(.nslot(1)) u_ba2 (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .req      ( ba2_slot_req ),
        .line_addr( ba2_line     ),
        .fill     ( ba2_fill     ),
        .bank_req ( ba2_req      ),
        .bank_rsp ( ba2_rsp      )
    );

    rom_slot #(
        .data_t   ( cps_rom_pkg::line_t      ),
        .addr_w   ( cps_rom_pkg::gfx_aw      ),
        .offset   ( cps_rom_pkg::rom0_offset )
    ) u_rom0 (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .cs       ( rom0_cs         ),
        .addr     ( rom0_addr       ),
        .data     ( rom0_data       ),
        .ok       ( rom0_ok         ),
        .req      ( ba3_slot_req[0] ),
        .line_addr( ba3_line[0]     ),
        .fill     ( ba3_fill[0]     ),
        .data_read( data_read       )
    );

    rom_slot #(
        .data_t   ( cps_rom_pkg::line_t      ),
        .addr_w   ( cps_rom_pkg::gfx_aw      ),
        .offset   ( cps_rom_pkg::rom1_offset )
    ) u_rom1 (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .cs       ( rom1_cs         ),
        .addr     ( rom1_addr       ),
        .data     ( rom1_data       ),
        .ok       ( rom1_ok         ),
        .req      ( ba3_slot_req[1] ),
        .line_addr( ba3_line[1]     ),
        .fill     ( ba3_fill[1]     ),
        .data_read( data_read       )
    );

    bank_arbiter #(.nslot(2)) u_ba3 (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .req      ( ba3_slot_req ),
        .line_addr( ba3_line     ),
        .fill     ( ba3_fill     ),
        .bank_req ( ba3_req      ),
        .bank_rsp ( ba3_rsp      )
    );

endmodule

`default_nettype wire

//--- cps_rom_router_assert.sv
/*
 * Bank handshake assertions for the CPS ROM router
 * rd holds until ack, the address stays put meanwhile, no rd in reset
 */
`timescale 1ns/100ps
`default_nettype none

module cps_rom_router_assert (
    input logic                   clk,
    input logic                   rst_n,
    input cps_rom_pkg::bank_req_t ba1_req,
    input cps_rom_pkg::bank_req_t ba2_req,
    input cps_rom_pkg::bank_req_t ba3_req,
    input cps_rom_pkg::bank_rsp_t ba1_rsp,
    input cps_rom_pkg::bank_rsp_t ba2_rsp,
    input cps_rom_pkg::bank_rsp_t ba3_rsp
);

    // rd stays up until the controller takes it
    a_ba1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba1_req.rd && !ba1_rsp.ack |=> ba1_req.rd) else $error("ba1 rd dropped before ack");
    a_ba2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba2_req.rd && !ba2_rsp.ack |=> ba2_req.rd) else $error("ba2 rd dropped before ack");
    a_ba3_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba3_req.rd && !ba3_rsp.ack |=> ba3_req.rd) else $error("ba3 rd dropped before ack");

    // Address stable while the read waits for ack
    a_ba1_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ba1_req.rd && !ba1_rsp.ack |=> $stable(ba1_req.addr)) else $error("ba1 addr moved");
    a_ba2_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ba2_req.rd && !ba2_rsp.ack |=> $stable(ba2_req.addr)) else $error("ba2 addr moved");
    a_ba3_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ba3_req.rd && !ba3_rsp.ack |=> $stable(ba3_req.addr)) else $error("ba3 addr moved");

    // One reset cycle clears every rd
    a_rst_rd: assert property (@(posedge clk)
        !rst_n |=> !(ba1_req.rd || ba2_req.rd || ba3_req.rd)) else $error("rd high in reset");

endmodule

bind cps_rom_router cps_rom_router_assert u_assert (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .ba1_req ( ba1_req ),
    .ba2_req ( ba2_req ),
    .ba3_req ( ba3_req ),
    .ba1_rsp ( ba1_rsp ),
    .ba2_rsp ( ba2_rsp ),
    .ba3_rsp ( ba3_rsp )
);

`default_nettype wire

//--- tb_cps_rom_router.sv
/*
 * Testbench for the CPS ROM router
 * Behavioral SDRAM responders on banks 1 to 3 and directed read tests
 * for every ROM client
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cps_rom_router;

    logic clk;
    logic rst_n;
    int   cyc;

    logic                            main_rom_cs, snd_cs, pcm_cs, rom0_cs, rom1_cs;
    logic [cps_rom_pkg::main_aw-1:0] main_rom_addr;
    logic [cps_rom_pkg::snd_aw-1:0]  snd_addr;
    logic [cps_rom_pkg::pcm_aw-1:0]  pcm_addr;
    logic [cps_rom_pkg::gfx_aw-1:0]  rom0_addr, rom1_addr;
    cps_rom_pkg::word_t              main_rom_data;
    cps_rom_pkg::byte_t              snd_data, pcm_data;
    cps_rom_pkg::line_t              rom0_data, rom1_data, data_read;
    logic                            main_rom_ok, snd_ok, pcm_ok, rom0_ok, rom1_ok;
    cps_rom_pkg::bank_req_t          ba1_req, ba2_req, ba3_req;

    // Responder state, indexed by bank number
    cps_rom_pkg::bank_rsp_t   rsp_a [1:3];
    cps_rom_pkg::line_t       line_a [1:3];
    logic                     slow [1:3];
    logic [22:0]              cur_addr [5];
    cps_rom_pkg::sdram_addr_t log1 [$];
    cps_rom_pkg::sdram_addr_t log2 [$];
    cps_rom_pkg::sdram_addr_t log3 [$];
    logic [3:1]               rd_prev;

    cps_rom_router uut (
        .clk(clk), .rst_n(rst_n),
        .main_rom_cs(main_rom_cs), .main_rom_addr(main_rom_addr),
        .main_rom_data(main_rom_data), .main_rom_ok(main_rom_ok),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_data(snd_data), .snd_ok(snd_ok),
        .pcm_cs(pcm_cs), .pcm_addr(pcm_addr), .pcm_data(pcm_data), .pcm_ok(pcm_ok),
        .rom0_cs(rom0_cs), .rom0_addr(rom0_addr), .rom0_data(rom0_data), .rom0_ok(rom0_ok),
        .rom1_cs(rom1_cs), .rom1_addr(rom1_addr), .rom1_data(rom1_data), .rom1_ok(rom1_ok),
        .ba1_req(ba1_req), .ba2_req(ba2_req), .ba3_req(ba3_req),
        .ba1_rsp(rsp_a[1]), .ba2_rsp(rsp_a[2]), .ba3_rsp(rsp_a[3]),
        .data_read(data_read)
    );

    // Only one bank gives rdy in a cycle, so the bus is an OR of the banks
    assign data_read = (rsp_a[1].rdy ? line_a[1] : '0) | (rsp_a[2].rdy ? line_a[2] : '0)
                     | (rsp_a[3].rdy ? line_a[3] : '0);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Content rule of the SDRAM model
    function automatic logic [15:0] word_at(input cps_rom_pkg::sdram_addr_t w, input int b);
        return w[15:0] ^ 16'ha5c3 ^ 16'(b << 12);
    endfunction

    function automatic cps_rom_pkg::line_t line_at(input cps_rom_pkg::sdram_addr_t w,
                                                   input int b);
        return {word_at(w + 22'd1, b), word_at(w, b)};
    endfunction

    task automatic serve_bank(input int b);
        int                       d;
        cps_rom_pkg::sdram_addr_t a;
        rsp_a[b]  = '0;
        line_a[b] = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && rd_of(b)) begin
                a = addr_of(b);
                d = slow[b] ? 3 : 1 + int'($urandom % 3);
                repeat (d - 1) begin
                    @(posedge clk);
                    #1;
                end
                rsp_a[b].ack = 1'b1;
                @(posedge clk);
                #1;
                rsp_a[b].ack = 1'b0;
                d = 1 + int'($urandom % 4);
                repeat (d - 1) begin
                    @(posedge clk);
                    #1;
                end
                // Each bank owns every third cycle for rdy
                while (cyc % 3 != b - 1) begin
                    @(posedge clk);
                    #1;
                end
                rsp_a[b].rdy = 1'b1;
                line_a[b]    = line_at(a, b);
                @(posedge clk);
                #1;
                rsp_a[b].rdy = 1'b0;
            end
        end
    endtask

    initial serve_bank(1);
    initial serve_bank(2);
    initial serve_bank(3);

    // Log every read issued on each bank
    always @(negedge clk) begin
        if (ba1_req.rd && !rd_prev[1]) log1.push_back(ba1_req.addr);
        if (ba2_req.rd && !rd_prev[2]) log2.push_back(ba2_req.addr);
        if (ba3_req.rd && !rd_prev[3]) log3.push_back(ba3_req.addr);
        rd_prev <= {ba3_req.rd, ba2_req.rd, ba1_req.rd};
    end

    function automatic logic rd_of(input int b);
        return (b == 1) ? ba1_req.rd : (b == 2) ? ba2_req.rd : ba3_req.rd;
    endfunction

    function automatic cps_rom_pkg::sdram_addr_t addr_of(input int b);
        return (b == 1) ? ba1_req.addr : (b == 2) ? ba2_req.addr : ba3_req.addr;
    endfunction

    // Client ids 0 main, 1 snd, 2 pcm, 3 rom0, 4 rom1
    function automatic int bank_of(input int id);
        return (id == 0) ? 2 : (id < 3) ? 1 : 3;
    endfunction

    function automatic logic ok_of(input int id);
        logic [4:0] oks;
        oks = {rom1_ok, rom0_ok, pcm_ok, snd_ok, main_rom_ok};
        return oks[id];
    endfunction

    function automatic logic [31:0] data_of(input int id);
        case (id)
            0: return {16'h0, main_rom_data};
            1: return {24'h0, snd_data};
            2: return {24'h0, pcm_data};
            3: return rom0_data;
            default: return rom1_data;
        endcase
    endfunction

    function automatic cps_rom_pkg::sdram_addr_t exp_line_addr(input int id,
                                                               input logic [22:0] a);
        case (id)
            0: return cps_rom_pkg::main_offset + {a[20:1], 1'b0};
            1: return cps_rom_pkg::snd_offset + 22'({a[18:2], 1'b0});
            2: return cps_rom_pkg::pcm_offset + {a[22:2], 1'b0};
            3: return cps_rom_pkg::rom0_offset + {a[19:0], 1'b0};
            default: return cps_rom_pkg::rom1_offset + {a[19:0], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] exp_data(input int id, input logic [22:0] a);
        cps_rom_pkg::line_t l;
        int                 sel;
        l   = line_at(exp_line_addr(id, a), bank_of(id));
        sel = int'(a[1:0]);
        if (id == 0) return {16'h0, a[0] ? l[31:16] : l[15:0]};
        if (id < 3) return {24'h0, l[8*sel +: 8]};
        return l;
    endfunction

    task automatic set_client(input int id, input logic cs, input logic [22:0] a);
        cur_addr[id] = a;
        case (id)
            0: begin
                main_rom_cs   = cs;
                main_rom_addr = a[20:0];
            end
            1: begin
                snd_cs   = cs;
                snd_addr = a[18:0];
            end
            2: begin
                pcm_cs   = cs;
                pcm_addr = a;
            end
            3: begin
                rom0_cs   = cs;
                rom0_addr = a[19:0];
            end
            default: begin
                rom1_cs   = cs;
                rom1_addr = a[19:0];
            end
        endcase
    endtask

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
            fail($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
    endtask

    // Waits for ok on every client in mask and checks each one as it arrives
    task automatic wait_many(input logic [4:0] mask, input string name);
        logic [4:0] done;
        int         n;
        done = '0;
        n    = 0;
        while (done != mask) begin
            for (int i = 0; i < 5; i++) begin
                if (mask[i] && !done[i] && ok_of(i)) begin
                    check(name, exp_data(i, cur_addr[i]), data_of(i));
                    done[i] = 1'b1;
                end
            end
            if (done != mask) begin
                @(posedge clk);
                #3;
                n++;
                if (n > 200) fail($sformatf("%s: timed out waiting for ok", name));
            end
        end
    endtask

    task automatic read_one(input int id, input logic [22:0] a, input string name);
        @(posedge clk);
        #1;
        set_client(id, 1'b1, a);
        #2;
        wait_many(5'(1 << id), name);
        @(posedge clk);
        #1;
        set_client(id, 1'b0, a);
    endtask

    task automatic test_reset();
        for (int i = 0; i < 5; i++) set_client(i, 1'b1, 23'h0);
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #1;
            check("test_reset rd", 32'h0, {29'h0, ba3_req.rd, ba2_req.rd, ba1_req.rd});
            check("test_reset ok", 32'h0, 32'({rom1_ok, rom0_ok, pcm_ok, snd_ok, main_rom_ok}));
        end
        for (int i = 0; i < 5; i++) set_client(i, 1'b0, 23'h0);
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check("test_reset idle", 32'h0, {29'h0, ba3_req.rd, ba2_req.rd, ba1_req.rd});
        end
    endtask

    task automatic test_main_rom_read();
        logic [22:0] addrs [4] = '{23'h10, 23'h11, 23'h1abcd, 23'h0f00e};
        foreach (addrs[i]) begin
            read_one(0, addrs[i], "test_main_rom_read");
            check("test_main_rom_read ba2_addr", 32'(exp_line_addr(0, addrs[i])),
                  32'(log2[$]));
        end
    endtask

    task automatic test_snd_bytes();
        @(posedge clk);
        #1;
        set_client(1, 1'b1, 23'h1234);
        #2;
        wait_many(5'b00010, "test_snd_bytes miss");
        for (int b = 1; b < 4; b++) begin
            @(posedge clk);
            #1;
            set_client(1, 1'b1, 23'h1234 + 23'(b));
            #2;
            check("test_snd_bytes hit ok", 32'h1, 32'(snd_ok));
            check("test_snd_bytes data", exp_data(1, cur_addr[1]), data_of(1));
            check("test_snd_bytes ba1_rd", 32'h0, 32'(ba1_req.rd));
        end
        @(posedge clk);
        #1;
        set_client(1, 1'b0, 23'h1234);
    endtask

    task automatic test_bank1_shared();
        log1.delete();
        @(posedge clk);
        #1;
        set_client(1, 1'b1, 23'h2_0402);
        set_client(2, 1'b1, 23'h45_6781);
        #2;
        wait_many(5'b00110, "test_bank1_shared");
        check("test_bank1_shared reads", 32'd2, 32'(log1.size()));
        // Sound was served last on bank 1, so round robin takes PCM first
        check("test_bank1_shared pcm addr", 32'(exp_line_addr(2, cur_addr[2])),
              32'(log1[0]));
        check("test_bank1_shared snd addr", 32'(exp_line_addr(1, cur_addr[1])),
              32'(log1[1]));
        @(posedge clk);
        #1;
        set_client(1, 1'b0, cur_addr[1]);
        set_client(2, 1'b0, cur_addr[2]);
    endtask

    task automatic test_gfx_backpressure();
        slow[3] = 1'b1;
        for (int i = 0; i < 4; i++) begin
            read_one(3, 23'(20'h0_0100 + 20'(i * 3)), "test_gfx_backpressure rom0");
            check("test_gfx_backpressure rom0 addr", 32'(exp_line_addr(3, cur_addr[3])),
                  32'(log3[$]));
            read_one(4, 23'(20'h5_4320 + 20'(i * 5)), "test_gfx_backpressure rom1");
            check("test_gfx_backpressure rom1 addr", 32'(exp_line_addr(4, cur_addr[4])),
                  32'(log3[$]));
        end
        slow[3] = 1'b0;
    endtask

    task automatic test_parallel_banks();
        @(posedge clk);
        #1;
        set_client(0, 1'b1, 23'h1_5550);
        set_client(1, 1'b1, 23'h4_0101);
        set_client(3, 1'b1, 23'h8_8888);
        #2;
        wait_many(5'b01011, "test_parallel_banks");
        @(posedge clk);
        #1;
        set_client(0, 1'b0, cur_addr[0]);
        set_client(1, 1'b0, cur_addr[1]);
        set_client(3, 1'b0, cur_addr[3]);
    endtask

    initial begin
        void'($urandom(32'h58e8));
        rst_n   = 1'b0;
        cyc     = 0;
        rd_prev = '0;
        for (int b = 1; b <= 3; b++) slow[b] = 1'b0;
        for (int i = 0; i < 5; i++) set_client(i, 1'b0, 23'h0);
        test_reset();
        test_main_rom_read();
        test_snd_bytes();
        test_bank1_shared();
        test_gfx_backpressure();
        test_parallel_banks();
        repeat (5) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cps_rom_router.f
cps_rom_pkg.sv
rom_slot.sv
bank_arbiter.sv
cps_rom_router.sv
cps_rom_router_assert.sv
tb_cps_rom_router.sv

//--- run.sh
#!/bin/sh
# Compile and run the CPS ROM router testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module tb_cps_rom_router \
        -f cps_rom_router.f -o sim_cps_rom_router; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_cps_rom_router; then
    echo "Simulation run failed"
    exit 1
fi

exit 0
